// ==== bench/rv_bus_monitor.sv ====
/* ISA model of the core fed from the bus. Fetch words and load data come from the
   read data at each handshake; only word loads and stores are modeled. */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_monitor #(
    parameter rv_core_pkg::word_t PC_START_VAL = '0
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_mem_valid,
    input  logic                  i_mem_ready,
    input  rv_core_pkg::word_t    i_mem_addr,
    input  rv_core_pkg::word_t    i_mem_rdata,
    input  rv_core_pkg::word_t    i_mem_wdata,
    input  rv_core_pkg::byte_en_t i_mem_wen,
    output int                    o_err_count,
    output int                    o_txn_count
);
    import rv_core_pkg::*;

    word_t regs [0:31];
    word_t pc;
    logic  access_due;     // Fetched LW/SW still owes its data transfer
    word_t held_instr;

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] rd, input word_t val);
        if (rd != 5'd0) regs[rd] = val;
    endtask

    task automatic check_field(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, got %h", name, expected, actual);
            o_err_count++;
        end
    endtask

    // Everything except loads and stores
    task automatic retire(input word_t instr);
        logic [2:0] f3;
        logic [4:0] rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      target;
        f3     = instr[14:12];
        rd     = instr[11:7];
        a      = regs[instr[19:15]];
        b      = regs[instr[24:20]];
        imm_i  = {{20{instr[31]}}, instr[31:20]};
        target = pc + 32'd4;
        case (instr[6:0])
            OPC_LUI:     write_reg(rd, {instr[31:12], 12'h000});
            OPC_AUIPC:   write_reg(rd, pc + {instr[31:12], 12'h000});
            OPC_JAL: begin
                write_reg(rd, pc + 32'd4);
                target = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    write_reg(rd, pc + 32'd4);
                    target = (a + imm_i) & ~32'd1;
                end
            end
            OPC_BRANCH: begin
                if (branch_model(f3, a, b))
                    target = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_ALU_IMM: write_reg(rd, alu_model(f3, (f3 == 3'b101) && instr[30], a, imm_i));
            OPC_ALU_REG: write_reg(rd, alu_model(f3, instr[30], a, b));
            default: ;   // Unknown opcode, no writeback
        endcase
        pc = target;
    endtask

    task automatic finish_access(input word_t instr);
        word_t base;
        base = regs[instr[19:15]];
        if (instr[6:0] == OPC_STORE) begin
            check_field("o_mem_addr", base + {{20{instr[31]}}, instr[31:25], instr[11:7]},
                        i_mem_addr);
            check_field("o_mem_wen", word_t'(STROBE_WORD), word_t'(i_mem_wen));
            check_field("o_mem_data", regs[instr[24:20]], i_mem_wdata);
        end else begin
            check_field("o_mem_addr", base + {{20{instr[31]}}, instr[31:20]}, i_mem_addr);
            check_field("o_mem_wen", 32'h0, word_t'(i_mem_wen));
            write_reg(instr[11:7], i_mem_rdata);
        end
        pc         = pc + 32'd4;
        access_due = 1'b0;
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            pc          = PC_START_VAL;
            access_due  = 1'b0;
            o_err_count = 0;
            o_txn_count = 0;
        end else if (i_mem_valid && i_mem_ready) begin
            o_txn_count++;
            if (access_due) begin
                finish_access(held_instr);
            end else begin
                check_field("o_mem_addr", pc, i_mem_addr);
                check_field("o_mem_wen", 32'h0, word_t'(i_mem_wen));
                if (i_mem_rdata[14:12] == 3'b010 &&
                    (i_mem_rdata[6:0] == OPC_LOAD || i_mem_rdata[6:0] == OPC_STORE)) begin
                    access_due = 1'b1;
                    held_instr = i_mem_rdata;
                end else begin
                    retire(i_mem_rdata);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/rv_core_chk.sv ====
/* Valid/ready bus checks on rv_core. fail_count holds the number of failed assertions. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk (
    input logic                  i_clk,
    input logic                  i_rst,
    input logic                  i_mem_valid,
    input logic                  i_mem_ready,
    input rv_core_pkg::word_t    i_mem_addr,
    input rv_core_pkg::word_t    i_mem_wdata,
    input rv_core_pkg::byte_en_t i_mem_wen
);
    int fail_count = 0;

    // Reset leaves the bus idle and reading
    reset_idle: assert property (@(posedge i_clk) i_rst |=> (!i_mem_valid && i_mem_wen == '0))
        else begin
            fail_count++;
            $error("bus not idle after a reset cycle");
        end

    hold_request: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_addr) &&
                                           $stable(i_mem_wdata) && $stable(i_mem_wen)))
        else begin
            fail_count++;
            $error("request changed or was withdrawn while waiting for ready");
        end

    drop_after_done: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_valid && i_mem_ready) |=> !i_mem_valid)
        else begin
            fail_count++;
            $error("valid still high in the cycle after a completed transfer");
        end

endmodule

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
/* Random RV32I program at 0, random data words at 0x1000. The memory model answers
   after 0 to 3 wait cycles; the run ends after a fixed count of checked transfers. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_core_pkg::*;

    localparam word_t PC_START_VAL   = 32'h0000_0000;
    localparam int    PROG_WORDS     = 256;
    localparam int    MEM_WORDS      = 2048;
    localparam int    DATA_BASE_WORD = 'h1000 / 4;
    localparam int    DATA_WORDS     = 64;
    localparam int    NUM_TXN        = 600;
    localparam int    RESET_CYCLES   = 4;
    localparam int    TIMEOUT_CYCLES = NUM_TXN * 20 + RESET_CYCLES;

    logic     clk;
    logic     rst;
    logic     mem_ready;
    word_t    mem_rdata;
    logic     mem_valid;
    word_t    mem_addr;
    word_t    mem_wdata;
    byte_en_t mem_wen;
    word_t    mem [0:MEM_WORDS-1];
    word_t    rand_state;
    int       wait_left;
    logic     serving;
    int       range_errors;
    int       total_errors;
    int       cycle_count = 0;
    int       err_count;
    int       txn_count;

    rv_core #(.PC_START_VAL(PC_START_VAL)) dut0 (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_mem_ready (mem_ready),
        .i_mem_data  (mem_rdata),
        .o_mem_valid (mem_valid),
        .o_mem_addr  (mem_addr),
        .o_mem_data  (mem_wdata),
        .o_mem_wen   (mem_wen)
    );

    rv_bus_monitor #(.PC_START_VAL(PC_START_VAL)) mon0 (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_mem_valid (mem_valid),
        .i_mem_ready (mem_ready),
        .i_mem_addr  (mem_addr),
        .i_mem_rdata (mem_rdata),
        .i_mem_wdata (mem_wdata),
        .i_mem_wen   (mem_wen),
        .o_err_count (err_count),
        .o_txn_count (txn_count)
    );

    bind rv_core rv_core_chk chk0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_mem_valid (o_mem_valid),
        .i_mem_ready (i_mem_ready),
        .i_mem_addr  (o_mem_addr),
        .i_mem_wdata (o_mem_data),
        .i_mem_wen   (o_mem_wen)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and program image
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Upper half only, low LCG bits have short periods
    function automatic int rand_below(input int n);
        word_t r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    function automatic word_t rand_word();
        word_t hi;
        word_t lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    task automatic build_program();
        word_t       instr;
        word_t       rnd;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [11:0] off;
        int          kind;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {~i[15:0], i[15:0]};
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            mem[DATA_BASE_WORD + i] = rand_word();
        end
        mem[0]            = {20'h00001, 5'd31, OPC_LUI};   // x31 = 0x1000
        mem[PROG_WORDS-1] = {20'h00000, 5'd0, OPC_JAL};    // Spin in place
        for (int i = 1; i < PROG_WORDS - 1; i++) begin
            rnd  = rand_word();
            rd   = reg_idx_t'(rand_below(31));             // Never x31
            rs1  = reg_idx_t'(rand_below(32));
            rs2  = reg_idx_t'(rand_below(32));
            f3   = 3'(rand_below(8));
            imm  = rnd[11:0];
            off  = 12'(rand_below(DATA_WORDS) * 4);
            kind = rand_below(16);
            if (i == PROG_WORDS - 2 && kind >= 12) kind = 0;   // Would jump past the end
            case (kind)
                0, 1, 2, 3: begin
                    instr = {7'b0, rs2, rs1, f3, rd, OPC_ALU_REG};
                    if ((f3 == 3'b000 || f3 == 3'b101) && rnd[20]) instr[30] = 1'b1;
                end
                4, 5, 6: begin
                    if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
                    else if (f3 == 3'b101) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    instr = {imm, rs1, f3, rd, OPC_ALU_IMM};
                end
                7:      instr = {rnd[31:12], rd, OPC_LUI};
                8:      instr = {rnd[31:12], rd, OPC_AUIPC};
                9, 10:  instr = {off[11:5], rs2, 5'd31, 3'b010, off[4:0], OPC_STORE};
                11:     instr = {off, 5'd31, 3'b010, rd, OPC_LOAD};
                12, 13: begin
                    if (f3[2:1] == 2'b01) f3[1] = 1'b0;  // Skip reserved conditions
                    instr = {7'b0, rs2, rs1, f3, 4'b0100, 1'b0, OPC_BRANCH};  // +8
                end
                14:      instr = {1'b0, 10'd4, 1'b0, 8'd0, rd, OPC_JAL};      // +8
                default: instr = {12'(i * 4 + 8), 5'd0, 3'b000, rd, OPC_JALR};
            endcase
            mem[i] = instr;
        end
    endtask

    task automatic serve_request();
        int idx;
        if (mem_addr >= word_t'(MEM_WORDS * 4)) begin
            $display("Bus access at address %h lies outside the memory model", mem_addr);
            range_errors++;
            mem_rdata = '0;
        end else begin
            idx       = int'(mem_addr[12:2]);
            mem_rdata = mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (mem_wen[b]) mem[idx][8*b +: 8] = mem_wdata[8*b +: 8];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model, one transfer at a time
    always @(negedge clk) begin
        if (rst) begin
            mem_ready = 1'b0;
            serving   = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;                 // Handshake on the last rising edge
        end else if (mem_valid) begin
            if (!serving) begin
                serving   = 1'b1;
                wait_left = rand_below(4);
            end
            if (wait_left == 0) begin
                serve_request();
                mem_ready = 1'b1;
                serving   = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: only %0d transfers seen after %0d cycles", txn_count, cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        serving      = 1'b0;
        wait_left    = 0;
        range_errors = 0;
        rand_state   = 32'd28298;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (txn_count < NUM_TXN) @(negedge clk);
        total_errors = err_count + range_errors;
        $display("Checked %0d transfers: %0d errors, %0d assertion failures",
                 txn_count, total_errors, dut0.chk0.fail_count);
        if (total_errors == 0 && dut0.chk0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
/* Ten-function ALU plus branch compare, both registered on i_en.
   Shifts use the low five bits of operand b. */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  logic                        i_clk,
    input  logic                        i_en,
    input  rv_core_pkg::decoded_instr_t i_dec,
    input  rv_core_pkg::word_t          i_op_a,
    input  rv_core_pkg::word_t          i_op_b,
    input  rv_core_pkg::word_t          i_rs1_val,
    input  rv_core_pkg::word_t          i_rs2_val,
    output rv_core_pkg::word_t          o_result,
    output logic                        o_take_branch
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    word_t      result_d;
    logic       take_d;

    assign shamt = i_op_b[4:0];

    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:  result_d = i_op_a + i_op_b;
            ALU_SUB:  result_d = i_op_a - i_op_b;
            ALU_SLL:  result_d = i_op_a << shamt;
            ALU_SLT:  result_d = {31'b0, $signed(i_op_a) < $signed(i_op_b)};
            ALU_SLTU: result_d = {31'b0, i_op_a < i_op_b};
            ALU_XOR:  result_d = i_op_a ^ i_op_b;
            ALU_SRL:  result_d = i_op_a >> shamt;
            ALU_SRA:  result_d = word_t'($signed(i_op_a) >>> shamt);
            ALU_OR:   result_d = i_op_a | i_op_b;
            ALU_AND:  result_d = i_op_a & i_op_b;
            default:  result_d = i_op_a + i_op_b;
        endcase
    end

    // Compare on the raw register values, operands carry pc and offset
    always_comb begin
        case (i_dec.br_op)
            BR_EQ:   take_d = (i_rs1_val == i_rs2_val);
            BR_NE:   take_d = (i_rs1_val != i_rs2_val);
            BR_LT:   take_d = ($signed(i_rs1_val) < $signed(i_rs2_val));
            BR_GE:   take_d = ($signed(i_rs1_val) >= $signed(i_rs2_val));
            BR_LTU:  take_d = (i_rs1_val < i_rs2_val);
            BR_GEU:  take_d = (i_rs1_val >= i_rs2_val);
            default: take_d = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_result      <= result_d;
            o_take_branch <= take_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
/* Multi-cycle RV32I core, LW/SW only and no misaligned access. No CSRs, no traps:
   unknown opcodes retire without writeback. */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_core_pkg::word_t PC_START_VAL = '0
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_mem_ready,
    input  rv_core_pkg::word_t    i_mem_data,
    output logic                  o_mem_valid,
    output rv_core_pkg::word_t    o_mem_addr,
    output rv_core_pkg::word_t    o_mem_data,
    output rv_core_pkg::byte_en_t o_mem_wen
);
    import rv_core_pkg::*;

    core_stage_e    stage;
    logic           mem_busy;
    logic           mem_start;
    logic           mem_done;
    mem_req_t       mem_req;
    word_t          mem_rdata;
    word_t          pc;
    word_t          next_pc;
    word_t          op_a_q;
    word_t          op_b_q;
    decoded_instr_t dec;
    word_t          rs1_val;
    word_t          rs2_val;
    word_t          alu_result;
    logic           take_branch;
    logic           rd_we;
    word_t          rd_wdata;
    logic           is_jump;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory requests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mem_start = (stage == STG_FETCH || stage == STG_ACCESS) && !mem_busy;

    always_comb begin
        mem_req = '0;
        if (stage == STG_FETCH) begin
            mem_req.addr = next_pc;
        end else begin
            mem_req.addr = alu_result;               // rs1 + offset
            if (dec.cls == CLS_STORE) begin
                mem_req.wdata = rs2_val;
                mem_req.strb  = STROBE_WORD;
            end
        end
    end

    rv_mem_port mem_port0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (mem_start),
        .i_req       (mem_req),
        .o_done      (mem_done),
        .o_rdata     (mem_rdata),
        .o_mem_valid (o_mem_valid),
        .i_mem_ready (i_mem_ready),
        .o_mem_addr  (o_mem_addr),
        .i_mem_data  (i_mem_data),
        .o_mem_data  (o_mem_data),
        .o_mem_wen   (o_mem_wen)
    );

    rv_decoder decoder0 (
        .i_clk   (i_clk),
        .i_en    (stage == STG_DECODE),
        .i_instr (mem_rdata),
        .o_dec   (dec)
    );

    rv_regfile regfile0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (rd_we),
        .i_waddr   (dec.rd),
        .i_wdata   (rd_wdata),
        .i_raddr_a (dec.rs1),
        .i_raddr_b (dec.rs2),
        .o_rdata_a (rs1_val),
        .o_rdata_b (rs2_val)
    );

    // Operand select, pc-relative forms take pc
    always_ff @(posedge i_clk) begin
        if (stage == STG_PREPARE) begin
            op_a_q <= (dec.cls inside {CLS_AUIPC, CLS_JAL, CLS_BRANCH}) ? pc : rs1_val;
            op_b_q <= (dec.cls == CLS_ALU_REG) ? rs2_val : dec.imm;
        end
    end

    rv_alu alu0 (
        .i_clk         (i_clk),
        .i_en          (stage == STG_EXECUTE),
        .i_dec         (dec),
        .i_op_a        (op_a_q),
        .i_op_b        (op_b_q),
        .i_rs1_val     (rs1_val),
        .i_rs2_val     (rs2_val),
        .o_result      (alu_result),
        .o_take_branch (take_branch)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_jump = (dec.cls == CLS_JAL) || (dec.cls == CLS_JALR);
    assign rd_we   = (stage == STG_WRITEBACK) &&
                     (dec.cls inside {CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_AUIPC,
                                      CLS_JAL, CLS_JALR, CLS_LOAD});

    always_comb begin
        case (dec.cls)
            CLS_LUI:           rd_wdata = dec.imm;
            CLS_JAL, CLS_JALR: rd_wdata = next_pc;   // Link, already pc + 4
            CLS_LOAD:          rd_wdata = mem_rdata;
            default:           rd_wdata = alu_result;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage    <= STG_FETCH;
            mem_busy <= 1'b0;
            pc       <= PC_START_VAL;
            next_pc  <= PC_START_VAL;
        end else begin
            case (stage)
                STG_FETCH: begin
                    if (mem_start) begin
                        mem_busy <= 1'b1;
                        pc       <= next_pc;
                        next_pc  <= next_pc + 32'd4;
                    end
                    if (mem_done) begin
                        mem_busy <= 1'b0;
                        stage    <= STG_DECODE;
                    end
                end
                STG_DECODE:  stage <= STG_PREPARE;
                STG_PREPARE: stage <= STG_EXECUTE;
                STG_EXECUTE: begin
                    stage <= (dec.cls inside {CLS_LOAD, CLS_STORE}) ? STG_ACCESS
                                                                     : STG_WRITEBACK;
                end
                STG_ACCESS: begin
                    if (mem_start) mem_busy <= 1'b1;
                    if (mem_done) begin
                        mem_busy <= 1'b0;
                        stage    <= (dec.cls == CLS_STORE) ? STG_FETCH : STG_WRITEBACK;
                    end
                end
                STG_WRITEBACK: begin
                    if (dec.cls == CLS_JALR) next_pc <= {alu_result[31:1], 1'b0};
                    else if (is_jump || (dec.cls == CLS_BRANCH && take_branch))
                        next_pc <= alu_result;
                    stage <= STG_FETCH;
                end
                default: stage <= STG_FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core_pkg.sv ====
/* Shared types of the RV32I core. Word accesses only, addresses assumed word aligned.
   CLS_NOP covers every encoding the decoder does not accept. */
`default_nettype none

package rv_core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    localparam byte_en_t STROBE_WORD = 4'b1111;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Enums
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_NOP
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Encoded as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_e;

    typedef enum logic [2:0] {
        STG_FETCH,
        STG_DECODE,
        STG_PREPARE,
        STG_EXECUTE,
        STG_ACCESS,
        STG_WRITEBACK
    } core_stage_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Structs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        branch_op_e   br_op;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        word_t        imm;     // Sign extended
    } decoded_instr_t;

    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t strb;        // All zero for reads
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/rv_decoder.sv ====
/* RV32I decoder, output registered on i_en. Rejected encodings leave as CLS_NOP. */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic                        i_clk,
    input  logic                        i_en,
    input  rv_core_pkg::word_t          i_instr,
    output rv_core_pkg::decoded_instr_t o_dec
);
    import rv_core_pkg::*;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    word_t          imm_i;
    word_t          imm_s;
    word_t          imm_b;
    word_t          imm_u;
    word_t          imm_j;
    logic           legal;
    decoded_instr_t dec_d;

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        dec_d        = '0;
        dec_d.cls    = CLS_NOP;
        dec_d.alu_op = ALU_ADD;     // Address and link arithmetic
        dec_d.br_op  = BR_EQ;
        dec_d.rd     = i_instr[11:7];
        dec_d.rs1    = i_instr[19:15];
        dec_d.rs2    = i_instr[24:20];
        dec_d.imm    = imm_i;
        legal        = 1'b0;
        case (opcode)
            OPC_LUI: begin
                dec_d.cls = CLS_LUI;
                dec_d.imm = imm_u;
            end
            OPC_AUIPC: begin
                dec_d.cls = CLS_AUIPC;
                dec_d.imm = imm_u;
            end
            OPC_JAL: begin
                dec_d.cls = CLS_JAL;
                dec_d.imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) dec_d.cls = CLS_JALR;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin   // 010 and 011 are reserved
                    dec_d.cls   = CLS_BRANCH;
                    dec_d.br_op = branch_op_e'(funct3);
                    dec_d.imm   = imm_b;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) dec_d.cls = CLS_LOAD;   // LW only
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) dec_d.cls = CLS_STORE;  // SW only
                dec_d.imm = imm_s;
            end
            OPC_ALU_IMM: begin
                if (funct3 == 3'b001) legal = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101) legal = (funct7 == 7'b0000000) ||
                                                   (funct7 == 7'b0100000);
                else legal = 1'b1;
                if (legal) begin
                    dec_d.cls    = CLS_ALU_IMM;
                    dec_d.alu_op = alu_from_funct(funct3, (funct3 == 3'b101) && i_instr[30]);
                end
            end
            OPC_ALU_REG: begin
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                if (legal) begin
                    dec_d.cls    = CLS_ALU_REG;
                    dec_d.alu_op = alu_from_funct(funct3, i_instr[30]);
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_en) o_dec <= dec_d;
    end

endmodule

`default_nettype wire

// ==== logic/rv_mem_port.sv ====
/* Single outstanding valid/ready request. i_start must not pulse while a request is open. */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_port (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  rv_core_pkg::mem_req_t i_req,
    output logic                  o_done,
    output rv_core_pkg::word_t    o_rdata,
    output logic                  o_mem_valid,
    input  logic                  i_mem_ready,
    output rv_core_pkg::word_t    o_mem_addr,
    input  rv_core_pkg::word_t    i_mem_data,
    output rv_core_pkg::word_t    o_mem_data,
    output rv_core_pkg::byte_en_t o_mem_wen
);
    import rv_core_pkg::*;

    mem_req_t req_q;
    logic     handshake;

    assign handshake = o_mem_valid && i_mem_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_valid <= 1'b0;
            o_done      <= 1'b0;
            req_q       <= '0;   // Keeps wen low out of reset
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                req_q       <= i_req;
                o_mem_valid <= 1'b1;
            end else if (handshake) begin
                o_mem_valid <= 1'b0;
                o_done      <= 1'b1;
            end
        end
    end

    // Held until the next request completes
    always_ff @(posedge i_clk) begin
        if (handshake) o_rdata <= i_mem_data;
    end

    assign o_mem_addr = req_q.addr;
    assign o_mem_data = req_q.wdata;
    assign o_mem_wen  = req_q.strb;

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
/* x1..x31 cleared on reset, x0 reads zero. Two combinational reads, one write. */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_we,
    input  rv_core_pkg::reg_idx_t i_waddr,
    input  rv_core_pkg::word_t    i_wdata,
    input  rv_core_pkg::reg_idx_t i_raddr_a,
    input  rv_core_pkg::reg_idx_t i_raddr_b,
    output rv_core_pkg::word_t    o_rdata_a,
    output rv_core_pkg::word_t    o_rdata_b
);
    import rv_core_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== project.f ====
logic/rv_core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_mem_port.sv
logic/rv_core.sv
bench/rv_core_chk.sv
bench/rv_bus_monitor.sv
bench/rv_core_tb.sv
